// File: build.f
common/lj_pkg.sv
pair_eval/pair_decode.sv
pair_eval/force_execute.sv
verilog/force_accumulate.sv
verilog/lj_pair_top.sv
verification/tb_clock_gen.sv
verification/lj_pair_asserts.sv
verification/lj_pair_tb.sv

// File: verification/lj_pair_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lj_pair_tb;
	import lj_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RANDOM_ROWS  = 40;
	localparam int PIPE_LATENCY = 5;              // pair_last edge to force_valid edge

	typedef struct packed {
		logic [3*CELL_ID_WIDTH-1:0]  hc;          // home cell {x, y, z}
		logic [3*CELL_POS_WIDTH-1:0] hp;          // home offset
		logic [3*CELL_ID_WIDTH-1:0]  nc;
		logic [3*CELL_POS_WIDTH-1:0] np;
		logic                        last;
		int                          gap;         // idle cycles after the row
		logic                        acc;         // expected: pair passes the filter
		int                          fx;          // expected components, 0 if rejected
		int                          fy;
		int                          fz;
	} row_t;

	typedef struct packed {
		int fx;
		int fy;
		int fz;
		int count;
	} group_t;

	logic                              clk;
	logic                              rst_n;
	logic                              pair_valid;
	logic                              pair_last;
	logic [3*CELL_ID_WIDTH-1:0]        home_cell;
	logic [3*CELL_ID_WIDTH-1:0]        nbr_cell;
	logic [3*CELL_POS_WIDTH-1:0]       home_pos;
	logic [3*CELL_POS_WIDTH-1:0]       nbr_pos;
	logic                              force_valid;
	logic signed [ACC_WIDTH-1:0]       force_x;
	logic signed [ACC_WIDTH-1:0]       force_y;
	logic signed [ACC_WIDTH-1:0]       force_z;
	logic [COUNT_WIDTH-1:0]            pair_count;

	row_t   rows[$];
	group_t exp_q[$];                           // expected groups in pulse order
	time    pulse_time_q[$];                    // negedge where each pulse is due
	integer seed;
	int     errors;
	int     groups_seen;
	int     groups_total;
	int     gap_sum;
	bit     table_ready;

	tb_clock_gen tb_clock_gen_i (.clk(clk));

	lj_pair_top lj_pair_top_i (
		.clk(clk), .rst_n(rst_n),
		.pair_valid(pair_valid), .pair_last(pair_last),
		.home_cell(home_cell), .nbr_cell(nbr_cell),
		.home_pos(home_pos), .nbr_pos(nbr_pos),
		.force_valid(force_valid),
		.force_x(force_x), .force_y(force_y), .force_z(force_z),
		.pair_count(pair_count)
	);

	function automatic logic [3*CELL_ID_WIDTH-1:0] pack_cell(int x, int y, int z);
		return {CELL_ID_WIDTH'(x), CELL_ID_WIDTH'(y), CELL_ID_WIDTH'(z)};
	endfunction

	function automatic logic [3*CELL_POS_WIDTH-1:0] pack_pos(int x, int y, int z);
		return {CELL_POS_WIDTH'(x), CELL_POS_WIDTH'(y), CELL_POS_WIDTH'(z)};
	endfunction

	// axis 0 is x, the top field
	function automatic int cell_coord(logic [3*CELL_ID_WIDTH-1:0] c, int a);
		return int'(c[(2-a)*CELL_ID_WIDTH +: CELL_ID_WIDTH]);
	endfunction

	function automatic int pos_coord(logic [3*CELL_POS_WIDTH-1:0] p, int a);
		return int'(p[(2-a)*CELL_POS_WIDTH +: CELL_POS_WIDTH]);
	endfunction

	// nearest periodic image along one axis
	function automatic int min_image_axis(int hc, int nc, int hp, int np);
		int d;
		d = (nc - hc) * CELL_SIZE + (np - hp);
		if (d > HALF_BOX) begin
			d = d - BOX_SIZE;
		end else if (d < -HALF_BOX) begin
			d = d + BOX_SIZE;
		end
		return d;
	endfunction

	function automatic row_t model_pair(row_t r);
		int d[3];
		int r2;
		int seg;
		int bin;
		int coef;
		for (int a = 0; a < 3; a++) begin
			d[a] = min_image_axis(cell_coord(r.hc, a), cell_coord(r.nc, a),
				pos_coord(r.hp, a), pos_coord(r.np, a));
		end
		r2    = d[0] * d[0] + d[1] * d[1] + d[2] * d[2];
		r.acc = (r2 >= MIN_R2) && (r2 < CUTOFF_2);
		r.fx  = 0;
		r.fy  = 0;
		r.fz  = 0;
		if (r.acc) begin
			seg  = r2 >> (BIN_WIDTH + FRAC_WIDTH);   // only in range for an accepted r2
			bin  = (r2 >> FRAC_WIDTH) % (1 << BIN_WIDTH);
			coef = int'(SEG_BASE[seg]) - int'(SEG_SLOPE[seg]) * bin;
			r.fx = (coef * d[0]) >>> FORCE_SHIFT;
			r.fy = (coef * d[1]) >>> FORCE_SHIFT;
			r.fz = (coef * d[2]) >>> FORCE_SHIFT;
		end
		return r;
	endfunction

	task automatic add_row(logic [3*CELL_ID_WIDTH-1:0] hc, logic [3*CELL_POS_WIDTH-1:0] hp,
		logic [3*CELL_ID_WIDTH-1:0] nc, logic [3*CELL_POS_WIDTH-1:0] np, logic last, int gap);
		row_t r;
		r      = '0;
		r.hc   = hc;
		r.hp   = hp;
		r.nc   = nc;
		r.np   = np;
		r.last = last;
		r.gap  = gap;
		rows.push_back(r);
	endtask

	// mostly short displacements across cell and box faces, some fully scattered
	task automatic add_random_rows(int n);
		int  h_c[3];
		int  h_p[3];
		int  n_c[3];
		int  n_p[3];
		int  off;
		bit  scatter;
		bit  closes;
		int  gap;
		for (int i = 0; i < n; i++) begin
			scatter = ($unsigned($random(seed)) % 4) == 0;
			for (int a = 0; a < 3; a++) begin
				h_c[a] = $unsigned($random(seed)) % DIM_CELLS;
				h_p[a] = $unsigned($random(seed)) % CELL_SIZE;
				off    = int'($unsigned($random(seed)) % 49) - 24;
				n_c[a] = h_c[a];
				n_p[a] = h_p[a] + off;
				if (scatter) begin
					n_c[a] = $unsigned($random(seed)) % DIM_CELLS;
					n_p[a] = $unsigned($random(seed)) % CELL_SIZE;
				end else if (n_p[a] < 0) begin
					n_p[a] = n_p[a] + CELL_SIZE;
					n_c[a] = (h_c[a] + DIM_CELLS - 1) % DIM_CELLS; // cell 0 steps to cell 2
				end else if (n_p[a] >= CELL_SIZE) begin
					n_p[a] = n_p[a] - CELL_SIZE;
					n_c[a] = (h_c[a] + 1) % DIM_CELLS;
				end
			end
			closes = ($unsigned($random(seed)) % 3) == 0;
			gap    = $unsigned($random(seed)) % 2;
			add_row(pack_cell(h_c[0], h_c[1], h_c[2]), pack_pos(h_p[0], h_p[1], h_p[2]),
				pack_cell(n_c[0], n_c[1], n_c[2]), pack_pos(n_p[0], n_p[1], n_p[2]),
				closes || (i == n - 1), gap);
		end
	endtask

	// fill the expected columns and fold them into per-group totals
	task automatic build_expected();
		group_t g;
		g = '0;
		for (int i = 0; i < rows.size(); i++) begin
			rows[i] = model_pair(rows[i]);
			gap_sum = gap_sum + rows[i].gap;
			if (rows[i].acc) begin
				g.fx    = g.fx + rows[i].fx;
				g.fy    = g.fy + rows[i].fy;
				g.fz    = g.fz + rows[i].fz;
				g.count = g.count + 1;
			end
			if (rows[i].last) begin
				exp_q.push_back(g);                  // rejected closing pair still closes
				groups_total = groups_total + 1;
				g = '0;
			end
		end
	endtask

	task automatic report_mismatch(string what, longint got, longint exp);
		errors = errors + 1;
		$display("[FAIL] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
	endtask

	initial begin
		seed         = 28;
		errors       = 0;
		groups_seen  = 0;
		groups_total = 0;
		gap_sum      = 0;
		table_ready  = 1'b0;
		rst_n        = 1'b0;
		pair_valid   = 1'b0;
		pair_last    = 1'b0;
		home_cell    = '0;
		nbr_cell     = '0;
		home_pos     = '0;
		nbr_pos      = '0;

		// wrap on each axis, both signs
		add_row(pack_cell(0,1,1), pack_pos(10,32,32), pack_cell(2,1,1), pack_pos(50,32,32), 1, 2);
		add_row(pack_cell(1,2,1), pack_pos(32,60,32), pack_cell(1,0,1), pack_pos(32,4,32), 1, 0);
		add_row(pack_cell(1,1,0), pack_pos(32,32,5), pack_cell(1,1,2), pack_pos(32,32,40), 1, 0);
		add_row(pack_cell(2,1,1), pack_pos(50,32,32), pack_cell(0,1,1), pack_pos(10,32,32), 1, 1);
		// group with every pair rejected: r2 = 4096, 4900, 0, 9
		add_row(pack_cell(1,1,1), pack_pos(0,32,32), pack_cell(2,1,1), pack_pos(0,32,32), 0, 0);
		add_row(pack_cell(1,1,1), pack_pos(0,32,32), pack_cell(2,1,1), pack_pos(6,32,32), 0, 0);
		add_row(pack_cell(1,1,1), pack_pos(20,20,20), pack_cell(1,1,1), pack_pos(20,20,20), 0, 0);
		add_row(pack_cell(1,1,1), pack_pos(20,20,20), pack_cell(1,1,1), pack_pos(23,20,20), 1, 3);
		// window edges, r2 = 16 and 4082
		add_row(pack_cell(1,1,1), pack_pos(20,20,20), pack_cell(1,1,1), pack_pos(24,20,20), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(0,10,10), pack_cell(1,1,1), pack_pos(63,18,17), 1, 0);
		// segment and bin boundaries, r2 = 17, 512, 528, 1024, 1536, 2048, 2560, 3072, 3584
		add_row(pack_cell(1,1,1), pack_pos(20,20,20), pack_cell(1,1,1), pack_pos(24,21,20), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(10,10,10), pack_cell(1,1,1), pack_pos(26,26,10), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(10,10,10), pack_cell(1,1,1), pack_pos(26,26,14), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(40,10,10), pack_cell(1,1,1), pack_pos(8,10,10), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(0,40,0), pack_cell(1,1,1), pack_pos(32,24,16), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(10,40,10), pack_cell(1,1,1), pack_pos(42,8,10), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(40,10,10), pack_cell(2,1,1), pack_pos(24,26,10), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(0,0,0), pack_cell(1,1,1), pack_pos(32,32,32), 1, 0);
		add_row(pack_cell(1,1,1), pack_pos(0,0,0), pack_cell(1,1,1), pack_pos(48,32,16), 1, 2);
		// five pairs, third and last rejected
		add_row(pack_cell(1,1,1), pack_pos(32,32,32), pack_cell(1,1,1), pack_pos(40,32,32), 0, 0);
		add_row(pack_cell(1,1,1), pack_pos(32,32,32), pack_cell(1,1,1), pack_pos(32,20,32), 0, 0);
		add_row(pack_cell(1,1,1), pack_pos(32,32,32), pack_cell(2,1,1), pack_pos(32,32,32), 0, 0);
		add_row(pack_cell(1,1,1), pack_pos(32,32,32), pack_cell(1,1,1), pack_pos(32,32,50), 0, 0);
		add_row(pack_cell(1,1,1), pack_pos(32,32,32), pack_cell(1,1,1), pack_pos(32,32,32), 1, 0);
		// back to back groups of one and two pairs
		add_row(pack_cell(0,0,0), pack_pos(60,60,60), pack_cell(1,0,0), pack_pos(2,60,60), 1, 0);
		add_row(pack_cell(0,0,0), pack_pos(60,60,60), pack_cell(0,1,0), pack_pos(60,3,60), 0, 0);
		add_row(pack_cell(0,0,0), pack_pos(60,60,60), pack_cell(0,0,1), pack_pos(60,60,1), 1, 0);
		add_row(pack_cell(2,2,2), pack_pos(60,60,60), pack_cell(0,0,0), pack_pos(2,2,2), 1, 0);
		add_random_rows(RANDOM_ROWS);
		build_expected();
		table_ready = 1'b1;

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			pair_valid <= 1'b1;
			pair_last  <= rows[i].last;
			home_cell  <= rows[i].hc;
			home_pos   <= rows[i].hp;
			nbr_cell   <= rows[i].nc;
			nbr_pos    <= rows[i].np;
			if (rows[i].last) begin
				pulse_time_q.push_back($time + PIPE_LATENCY * CLK_PERIOD + CLK_PERIOD / 2);
			end
			for (int g = 0; g < rows[i].gap; g++) begin
				@(posedge clk);
				pair_valid <= 1'b0;
				pair_last  <= 1'b0;
			end
		end
		@(posedge clk);
		pair_valid <= 1'b0;
		pair_last  <= 1'b0;

		repeat (PIPE_LATENCY + 4) @(negedge clk);  // last pulse plus room for a stray one
		if (exp_q.size() != 0) begin
			errors = errors + 1;
			$display("%0d expected group results never arrived", exp_q.size());
		end
		$display("errors: %0d, groups checked: %0d of %0d", errors, groups_seen, groups_total);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// mid-cycle sampling, outputs settled since the rising edge
	always @(negedge clk) begin
		group_t g;
		time    t_exp;
		if (!rst_n) begin
			if (force_valid === 1'b1) begin
				errors = errors + 1;
				$display("force_valid was high at %0t ns while reset was asserted", $time);
			end
		end else if (force_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors = errors + 1;
				$display("force_valid pulsed at %0t ns with no group pending", $time);
			end else begin
				g     = exp_q.pop_front();
				t_exp = pulse_time_q.pop_front();
				if ($time != t_exp) begin
					report_mismatch("pulse time", $time, t_exp);
				end
				if (force_x !== g.fx) begin
					report_mismatch("force_x", force_x, g.fx);
				end
				if (force_y !== g.fy) begin
					report_mismatch("force_y", force_y, g.fy);
				end
				if (force_z !== g.fz) begin
					report_mismatch("force_z", force_z, g.fz);
				end
				if (pair_count !== COUNT_WIDTH'(g.count)) begin
					report_mismatch("pair_count", pair_count, g.count);
				end
				groups_seen = groups_seen + 1;
			end
		end
	end

	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = (rows.size() + gap_sum + 20) * CLK_PERIOD;
		#(limit_ns);
		$display("timeout after %0d ns, %0d of %0d groups seen", limit_ns, groups_seen,
			groups_total);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/lj_pair_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module lj_pair_asserts (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              pair_valid,
	input  logic                              pair_last,
	input  logic                              force_valid,
	input  logic [lj_pkg::COUNT_WIDTH-1:0]    pair_count
);
	import lj_pkg::*;

	int open_pairs;                             // strobes since the last closing pair
	int closed_total;                           // group size if this strobe closes it

	assign closed_total = open_pairs + 1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			open_pairs <= 0;
		end else if (pair_valid) begin
			open_pairs <= pair_last ? 0 : open_pairs + 1;
		end
	end

	// closing pair shows up on force_valid five edges later
	a_last_to_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(pair_valid && pair_last) |-> ##5 force_valid)
		else $error("closing pair did not produce force_valid after 5 cycles");

	a_pulse_from_last: assert property (@(posedge clk) disable iff (!rst_n)
		force_valid |-> $past(pair_valid && pair_last, 5))
		else $error("force_valid without a closing pair 5 cycles earlier");

	a_quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> (force_valid !== 1'b1))
		else $error("force_valid high during reset");

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		force_valid |-> (pair_count <= $past(closed_total, 5)))
		else $error("pair_count larger than the pairs fed to the group");

endmodule

bind lj_pair_top lj_pair_asserts lj_pair_asserts_i (
	.clk(clk), .rst_n(rst_n),
	.pair_valid(pair_valid), .pair_last(pair_last),
	.force_valid(force_valid), .pair_count(pair_count)
);

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk
);
	localparam int HALF_PERIOD = 50;            // 100 ns period

	initial begin
		clk = 1'b0;                               // first rising edge at 50 ns
	end

	always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: verilog/lj_pair_top.sv
`timescale 1ns/1ns
`default_nettype none

module lj_pair_top (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   pair_valid,
	input  logic                                   pair_last,
	input  logic [3*lj_pkg::CELL_ID_WIDTH-1:0]     home_cell,
	input  logic [3*lj_pkg::CELL_ID_WIDTH-1:0]     nbr_cell,
	input  logic [3*lj_pkg::CELL_POS_WIDTH-1:0]    home_pos,
	input  logic [3*lj_pkg::CELL_POS_WIDTH-1:0]    nbr_pos,
	output logic                                   force_valid, // 5 cycles after pair_last
	output logic signed [lj_pkg::ACC_WIDTH-1:0]    force_x,
	output logic signed [lj_pkg::ACC_WIDTH-1:0]    force_y,
	output logic signed [lj_pkg::ACC_WIDTH-1:0]    force_z,
	output logic [lj_pkg::COUNT_WIDTH-1:0]         pair_count
);
	import lj_pkg::*;

	// decode to execute
	logic                          dec_valid;
	logic                          dec_last;
	logic signed [DISP_WIDTH-1:0]  dec_dx;
	logic signed [DISP_WIDTH-1:0]  dec_dy;
	logic signed [DISP_WIDTH-1:0]  dec_dz;
	r2_word_u                      dec_r2;

	// execute to result
	logic                          exe_valid;
	logic                          exe_last;
	logic signed [ACC_WIDTH-1:0]   exe_fx;
	logic signed [ACC_WIDTH-1:0]   exe_fy;
	logic signed [ACC_WIDTH-1:0]   exe_fz;

	pair_decode pair_decode_i (               // edges t+1, t+2
		.clk(clk), .rst_n(rst_n),
		.pair_valid(pair_valid), .pair_last(pair_last),
		.home_cell(home_cell), .nbr_cell(nbr_cell),
		.home_pos(home_pos), .nbr_pos(nbr_pos),
		.dec_valid(dec_valid), .dec_last(dec_last),
		.dec_dx(dec_dx), .dec_dy(dec_dy), .dec_dz(dec_dz),
		.dec_r2(dec_r2)
	);

	force_execute force_execute_i (           // edges t+3, t+4
		.clk(clk), .rst_n(rst_n),
		.dec_valid(dec_valid), .dec_last(dec_last),
		.dec_dx(dec_dx), .dec_dy(dec_dy), .dec_dz(dec_dz),
		.dec_r2(dec_r2),
		.exe_valid(exe_valid), .exe_last(exe_last),
		.exe_fx(exe_fx), .exe_fy(exe_fy), .exe_fz(exe_fz)
	);

	force_accumulate force_accumulate_i (     // edge t+5
		.clk(clk), .rst_n(rst_n),
		.exe_valid(exe_valid), .exe_last(exe_last),
		.exe_fx(exe_fx), .exe_fy(exe_fy), .exe_fz(exe_fz),
		.force_valid(force_valid),
		.force_x(force_x), .force_y(force_y), .force_z(force_z),
		.pair_count(pair_count)
	);

endmodule

`default_nettype wire

// File: verilog/force_accumulate.sv
`timescale 1ns/1ns
`default_nettype none

module force_accumulate (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    exe_valid,   // component is a real pair
	input  logic                                    exe_last,    // close the group this cycle
	input  logic signed [lj_pkg::ACC_WIDTH-1:0]     exe_fx,
	input  logic signed [lj_pkg::ACC_WIDTH-1:0]     exe_fy,
	input  logic signed [lj_pkg::ACC_WIDTH-1:0]     exe_fz,
	output logic                                    force_valid, // one-cycle pulse per group
	output logic signed [lj_pkg::ACC_WIDTH-1:0]     force_x,
	output logic signed [lj_pkg::ACC_WIDTH-1:0]     force_y,
	output logic signed [lj_pkg::ACC_WIDTH-1:0]     force_z,
	output logic [lj_pkg::COUNT_WIDTH-1:0]          pair_count
);
	import lj_pkg::*;

	logic signed [ACC_WIDTH-1:0]  acc_x;          // running sums for the open group
	logic signed [ACC_WIDTH-1:0]  acc_y;
	logic signed [ACC_WIDTH-1:0]  acc_z;
	logic [COUNT_WIDTH-1:0]       acc_count;

	logic signed [ACC_WIDTH-1:0]  add_x;          // zero for a filtered pair
	logic signed [ACC_WIDTH-1:0]  add_y;
	logic signed [ACC_WIDTH-1:0]  add_z;
	logic signed [ACC_WIDTH-1:0]  sum_x;          // sum including the current pair
	logic signed [ACC_WIDTH-1:0]  sum_y;
	logic signed [ACC_WIDTH-1:0]  sum_z;
	logic [COUNT_WIDTH-1:0]       sum_count;

	assign add_x     = exe_valid ? exe_fx : '0;
	assign add_y     = exe_valid ? exe_fy : '0;
	assign add_z     = exe_valid ? exe_fz : '0;
	assign sum_x     = acc_x + add_x;
	assign sum_y     = acc_y + add_y;
	assign sum_z     = acc_z + add_z;
	assign sum_count = acc_count + COUNT_WIDTH'(exe_valid);

	// running sums, restart from zero right after a closing pair
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_x     <= '0;
			acc_y     <= '0;
			acc_z     <= '0;
			acc_count <= '0;
		end else if (exe_last) begin
			acc_x     <= '0;                         // next group may start next cycle
			acc_y     <= '0;
			acc_z     <= '0;
			acc_count <= '0;
		end else begin
			acc_x     <= sum_x;
			acc_y     <= sum_y;
			acc_z     <= sum_z;
			acc_count <= sum_count;
		end
	end

	// group result, held until the next pulse
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			force_valid <= 1'b0;
			force_x     <= '0;
			force_y     <= '0;
			force_z     <= '0;
			pair_count  <= '0;
		end else begin
			force_valid <= exe_last;
			if (exe_last) begin
				force_x    <= sum_x;
				force_y    <= sum_y;
				force_z    <= sum_z;
				pair_count <= sum_count;                // 0 when every pair was rejected
			end
		end
	end

endmodule

`default_nettype wire

// File: pair_eval/force_execute.sv
`timescale 1ns/1ns
`default_nettype none

module force_execute (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    dec_valid,
	input  logic                                    dec_last,
	input  logic signed [lj_pkg::DISP_WIDTH-1:0]    dec_dx,
	input  logic signed [lj_pkg::DISP_WIDTH-1:0]    dec_dy,
	input  logic signed [lj_pkg::DISP_WIDTH-1:0]    dec_dz,
	input  lj_pkg::r2_word_u                        dec_r2,
	output logic                                    exe_valid,
	output logic                                    exe_last,
	output logic signed [lj_pkg::ACC_WIDTH-1:0]     exe_fx,  // coef * dx >>> FORCE_SHIFT
	output logic signed [lj_pkg::ACC_WIDTH-1:0]     exe_fy,
	output logic signed [lj_pkg::ACC_WIDTH-1:0]     exe_fz
);
	import lj_pkg::*;

	logic [SEGMENT_WIDTH-1:0]          seg;
	logic [BIN_WIDTH-1:0]              bin;
	logic [SLOPE_WIDTH+BIN_WIDTH-1:0]  slope_term;   // slope * bin, at most 7905
	logic signed [COEF_WIDTH-1:0]      coef_full;    // base - slope * bin

	logic                              s1_valid;
	logic                              s1_last;
	logic signed [COEF_WIDTH-1:0]      s1_coef;
	logic signed [DISP_WIDTH-1:0]      s1_dx;        // displacement lags one stage
	logic signed [DISP_WIDTH-1:0]      s1_dy;
	logic signed [DISP_WIDTH-1:0]      s1_dz;

	logic signed [ACC_WIDTH-1:0]       prod_x;       // full product, sign extended
	logic signed [ACC_WIDTH-1:0]       prod_y;
	logic signed [ACC_WIDTH-1:0]       prod_z;

	// stage 1, table view of r2 picks the segment and the step inside it
	assign seg        = dec_r2.tab.segment;
	assign bin        = dec_r2.tab.bin;
	assign slope_term = SEG_SLOPE[seg] * bin;
	assign coef_full  = SEG_BASE[seg] - $signed({1'b0, slope_term});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_last  <= 1'b0;
		end else begin
			s1_valid <= dec_valid;
			s1_last  <= dec_last;
		end
	end

	always_ff @(posedge clk) begin
		s1_coef <= coef_full;                    // table values keep this in 16 bits
		s1_dx   <= dec_dx;
		s1_dy   <= dec_dy;
		s1_dz   <= dec_dz;
	end

	// stage 2, scale each component, sign follows the displacement
	assign prod_x = s1_coef * s1_dx;
	assign prod_y = s1_coef * s1_dy;
	assign prod_z = s1_coef * s1_dz;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
			exe_last  <= 1'b0;
		end else begin
			exe_valid <= s1_valid;
			exe_last  <= s1_last;
		end
	end

	always_ff @(posedge clk) begin
		exe_fx <= prod_x >>> FORCE_SHIFT;         // arithmetic, rounds toward -inf
		exe_fy <= prod_y >>> FORCE_SHIFT;
		exe_fz <= prod_z >>> FORCE_SHIFT;
	end

endmodule

`default_nettype wire

// File: pair_eval/pair_decode.sv
`timescale 1ns/1ns
`default_nettype none

module pair_decode (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       pair_valid,
	input  logic                                       pair_last,  // closes a home group
	input  logic [3*lj_pkg::CELL_ID_WIDTH-1:0]         home_cell,  // {x, y, z}, x on top
	input  logic [3*lj_pkg::CELL_ID_WIDTH-1:0]         nbr_cell,
	input  logic [3*lj_pkg::CELL_POS_WIDTH-1:0]        home_pos,   // {x, y, z}, x on top
	input  logic [3*lj_pkg::CELL_POS_WIDTH-1:0]        nbr_pos,
	output logic                                       dec_valid,  // pair passed the filter
	output logic                                       dec_last,   // follows every input pair
	output logic signed [lj_pkg::DISP_WIDTH-1:0]       dec_dx,
	output logic signed [lj_pkg::DISP_WIDTH-1:0]       dec_dy,
	output logic signed [lj_pkg::DISP_WIDTH-1:0]       dec_dz,
	output lj_pkg::r2_word_u                           dec_r2
);
	import lj_pkg::*;

	localparam int CW = CELL_ID_WIDTH;
	localparam int PW = CELL_POS_WIDTH;

	logic                          s1_valid;
	logic                          s1_last;
	logic signed [DISP_WIDTH-1:0]  s1_dx;         // wrapped nbr - home
	logic signed [DISP_WIDTH-1:0]  s1_dy;
	logic signed [DISP_WIDTH-1:0]  s1_dz;

	logic signed [2*DISP_WIDTH-1:0] sq_x;         // up to 96^2
	logic signed [2*DISP_WIDTH-1:0] sq_y;
	logic signed [2*DISP_WIDTH-1:0] sq_z;
	logic signed [2*DISP_WIDTH+1:0] r2_full;      // up to 3*96^2, before the range check
	logic                           r2_in_range;

	// one axis of the minimum-image displacement from home to neighbour
	function automatic logic signed [DISP_WIDTH-1:0] min_image(
		input logic [CELL_ID_WIDTH-1:0]  hc,
		input logic [CELL_ID_WIDTH-1:0]  nc,
		input logic [CELL_POS_WIDTH-1:0] hp,
		input logic [CELL_POS_WIDTH-1:0] np
	);
		int d;
		d = (int'(nc) - int'(hc)) * CELL_SIZE + (int'(np) - int'(hp)); // -191..191
		if (d > HALF_BOX) begin
			d = d - BOX_SIZE;                          // neighbour is closer through the low face
		end else if (d < -HALF_BOX) begin
			d = d + BOX_SIZE;                          // closer through the high face
		end
		return DISP_WIDTH'(d);
	endfunction

	// stage 1, per-axis displacement with periodic wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_last  <= 1'b0;
		end else begin
			s1_valid <= pair_valid;
			s1_last  <= pair_valid & pair_last;      // last only counts with a strobe
		end
	end

	always_ff @(posedge clk) begin
		s1_dx <= min_image(home_cell[3*CW-1:2*CW], nbr_cell[3*CW-1:2*CW],
			home_pos[3*PW-1:2*PW], nbr_pos[3*PW-1:2*PW]);
		s1_dy <= min_image(home_cell[2*CW-1:CW], nbr_cell[2*CW-1:CW],
			home_pos[2*PW-1:PW], nbr_pos[2*PW-1:PW]);
		s1_dz <= min_image(home_cell[CW-1:0], nbr_cell[CW-1:0],
			home_pos[PW-1:0], nbr_pos[PW-1:0]);
	end

	// stage 2, squared distance and cutoff window
	assign sq_x        = s1_dx * s1_dx;
	assign sq_y        = s1_dy * s1_dy;
	assign sq_z        = s1_dz * s1_dz;
	assign r2_full     = sq_x + sq_y + sq_z;
	assign r2_in_range = (r2_full >= MIN_R2) && (r2_full < CUTOFF_2); // [16, 4096)

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			dec_last  <= 1'b0;
		end else begin
			dec_valid <= s1_valid & r2_in_range;      // rejected pairs vanish here
			dec_last  <= s1_last;                     // kept even when the pair is dropped
		end
	end

	always_ff @(posedge clk) begin
		dec_dx     <= s1_dx;
		dec_dy     <= s1_dy;
		dec_dz     <= s1_dz;
		dec_r2.raw <= r2_full[R2_WIDTH-1:0];       // exact whenever dec_valid is set
	end

endmodule

`default_nettype wire

// File: common/lj_pkg.sv
`default_nettype none

package lj_pkg;

	// box geometry, 3x3x3 cells of 64 units each
	localparam int CELL_ID_WIDTH  = 2;            // bits per cell coordinate
	localparam int DIM_CELLS      = 3;            // cells per dimension
	localparam int CELL_POS_WIDTH = 6;            // cell-local offset, 0..63
	localparam int CELL_SIZE      = 64;           // cell edge in length units
	localparam int BOX_SIZE       = DIM_CELLS * CELL_SIZE; // 192, not a power of two
	localparam int HALF_BOX       = BOX_SIZE / 2; // 96, minimum-image limit
	localparam int DISP_WIDTH     = 9;            // signed displacement, -96..96 after wrap

	// pair filter limits on r2
	localparam int CUTOFF_2 = 4096;               // cutoff radius 64, r2 at or above is dropped
	localparam int MIN_R2   = 16;                 // self pairs and overlaps fall below this
	localparam int R2_WIDTH = 12;                 // accepted r2 always fits 12 bits

	// piecewise-linear force/r table
	localparam int SEGMENT_NUM   = 8;
	localparam int SEGMENT_WIDTH = 3;             // r2[11:9]
	localparam int BIN_WIDTH     = 5;             // r2[8:4]
	localparam int FRAC_WIDTH    = 4;             // r2[3:0], below table resolution
	localparam int COEF_WIDTH    = 16;            // signed force/r coefficient
	localparam int SLOPE_WIDTH   = 8;             // unsigned per-segment slope
	localparam int FORCE_SHIFT   = 6;             // scale back after coef * displacement

	// coefficient = base - slope * bin, steep repulsive wall near r = 0,
	// shallow attractive tail toward the cutoff
	localparam logic signed [COEF_WIDTH-1:0] SEG_BASE [SEGMENT_NUM] = '{
		16'sd16000,                                 // r2    0..511
		16'sd8000,                                  // r2  512..1023
		16'sd1800,                                  // r2 1024..1535
		-16'sd60,                                   // r2 1536..2047, near the well minimum
		-16'sd310,
		-16'sd400,
		-16'sd300,
		-16'sd200                                   // r2 3584..4095
	};
	localparam logic [SLOPE_WIDTH-1:0] SEG_SLOPE [SEGMENT_NUM] = '{
		8'd255,                                     // worst case 255*31 stays in range
		8'd200,
		8'd60,
		8'd8,
		8'd3,
		8'd1,
		8'd2,
		8'd4
	};

	// result side
	localparam int ACC_WIDTH   = 32;              // signed force sums
	localparam int COUNT_WIDTH = 8;               // accepted pairs per group

	// one r2 word, seen raw by the filter and as a table address by execute
	typedef union packed {
		logic [R2_WIDTH-1:0] raw;                   // squared distance
		struct packed {
			logic [SEGMENT_WIDTH-1:0] segment;        // selects base and slope
			logic [BIN_WIDTH-1:0]     bin;            // linear step inside the segment
			logic [FRAC_WIDTH-1:0]    frac;           // dropped by the lookup
		} tab;
	} r2_word_u;

endpackage

`default_nettype wire
